/* filelist.f */
+incdir+.
inst_pkg.sv
trap_pkg.sv
commit_if.sv
branch_resolver.sv
trap_arbiter.sv
commit_ctrl.sv
commit_unit.sv
tb_commit_unit.sv

/* Bender.yml */
package:
  name: commit_unit

export_include_dirs:
  - .

sources:
  - inst_pkg.sv
  - trap_pkg.sv
  - commit_if.sv
  - branch_resolver.sv
  - trap_arbiter.sv
  - commit_ctrl.sv
  - commit_unit.sv
  - target: simulation
    files:
      - tb_commit_unit.sv

/* tb_commit_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "commit_defines.svh"

module tb_commit_unit;

	localparam int RUN_LEN = 3000;              // instructions to hand over
	localparam int TIMEOUT = RUN_LEN * 8 + 100; // cycles

	typedef struct packed
	{
		logic                     ready;
		logic                     valid;
		logic                     hs;        // handshake expected
		logic                     cmt;
		logic                     wbk;
		logic                     lsu_ready;
		logic                     enter;
		logic                     ret;
		logic                     is_intr;
		trap_pkg::trap_cause_u    cause;
		logic [`COMMIT_XLEN-1:0]  val;
		logic [`COMMIT_XLEN-1:0]  ret_addr;
		logic                     flush_req;
		logic [`COMMIT_XLEN-1:0]  flush_addr;
	} expect_t;

	logic clk;
	logic resetn;
	logic mstatus_mie, mie_msie, mie_mtie, mie_meie;
	logic [`COMMIT_XLEN-1:0] s_pst_inst, s_pst_pc, s_pst_brc_pc_upd;
	logic [`COMMIT_ERR_W-1:0] s_pst_err_code;
	logic s_pst_is_b, s_pst_is_ecall, s_pst_is_mret, s_pst_is_fence_i;
	logic s_pst_prdt_jump, s_pst_is_long, s_pst_valid, s_pst_ready;
	logic [`COMMIT_XLEN-1:0] s_lsu_expt_addr;
	logic s_lsu_expt_err, s_lsu_expt_valid, s_lsu_expt_ready;
	logic m_pst_inst_cmt, m_pst_need_imdt_wbk, m_pst_valid, m_pst_ready;
	logic [`COMMIT_XLEN-1:0] ls_addr;
	logic cfr_jump, sw_itr_req, tmr_itr_req, ext_itr_req;
	logic itr_expt_enter, itr_expt_is_intr, itr_expt_ret;
	trap_pkg::trap_cause_u itr_expt_cause;
	logic [`COMMIT_XLEN-1:0] itr_expt_vec_base, itr_expt_ret_addr, itr_expt_val;
	logic [`COMMIT_XLEN-1:0] mepc_ret_addr, flush_addr;
	logic flush_req, flush_ack;

	logic [31:0] lcg_state;  // random generator state
	logic        busy_m;     // model of the trap-in-progress flag
	logic        pend_m;     // model of the flush-pending flag
	logic        seen_req;   // flush_req of the last checked cycle
	logic        seen_ack;
	logic        waiting;    // flush_req out, ack not yet given
	int          ack_cnt;    // cycles left until ack
	logic [1:0]  ack_delay;  // delay for the next flush
	int          inst_cnt = 0;
	int          cycle_cnt = 0;
	int          n_intr = 0, n_expt = 0, n_lsu = 0;
	int          n_ret = 0, n_redirect = 0, n_stall = 0;
	expect_t     exp_now;

	commit_unit commit_unit_i
	(
		.clk(clk), .resetn(resetn),
		.mstatus_mie(mstatus_mie), .mie_msie(mie_msie), .mie_mtie(mie_mtie), .mie_meie(mie_meie),
		.s_pst_inst(s_pst_inst), .s_pst_err_code(s_pst_err_code), .s_pst_pc(s_pst_pc),
		.s_pst_is_b(s_pst_is_b), .s_pst_is_ecall(s_pst_is_ecall), .s_pst_is_mret(s_pst_is_mret),
		.s_pst_is_fence_i(s_pst_is_fence_i), .s_pst_brc_pc_upd(s_pst_brc_pc_upd),
		.s_pst_prdt_jump(s_pst_prdt_jump), .s_pst_is_long(s_pst_is_long),
		.s_pst_valid(s_pst_valid), .s_pst_ready(s_pst_ready),
		.s_lsu_expt_addr(s_lsu_expt_addr), .s_lsu_expt_err(s_lsu_expt_err),
		.s_lsu_expt_valid(s_lsu_expt_valid), .s_lsu_expt_ready(s_lsu_expt_ready),
		.m_pst_inst_cmt(m_pst_inst_cmt), .m_pst_need_imdt_wbk(m_pst_need_imdt_wbk),
		.m_pst_valid(m_pst_valid), .m_pst_ready(m_pst_ready),
		.ls_addr(ls_addr), .cfr_jump(cfr_jump),
		.sw_itr_req(sw_itr_req), .tmr_itr_req(tmr_itr_req), .ext_itr_req(ext_itr_req),
		.itr_expt_enter(itr_expt_enter), .itr_expt_is_intr(itr_expt_is_intr),
		.itr_expt_cause(itr_expt_cause), .itr_expt_vec_base(itr_expt_vec_base),
		.itr_expt_ret_addr(itr_expt_ret_addr), .itr_expt_val(itr_expt_val),
		.itr_expt_ret(itr_expt_ret), .mepc_ret_addr(mepc_ret_addr),
		.flush_req(flush_req), .flush_ack(flush_ack), .flush_addr(flush_addr)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk; // 20 ns period

	function automatic logic [31:0] lcg_step();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// upper halves only, low lcg bits repeat quickly
	function automatic logic [31:0] rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_step();
		lo = lcg_step();
		return {hi[31:16], lo[31:16]};
	endfunction

	// expected outputs from the current inputs and the model flags
	function automatic expect_t ref_model(input logic busy, input logic pend);
		expect_t e;
		logic no_err, misp, fence, mret, ecall;
		logic sw, tmr, ext, intr, lsu, sync, trap_req;
		logic take_trap, take_mret;
		e = '0;
		no_err = ~(s_pst_err_code[0] | s_pst_err_code[1]);
		e.ready = ~pend & m_pst_ready;
		e.valid = ~pend & s_pst_valid;
		e.hs = s_pst_valid & e.ready;
		misp = s_pst_valid & no_err & s_pst_is_b & (s_pst_prdt_jump ^ cfr_jump);
		fence = s_pst_valid & no_err & s_pst_is_fence_i;
		mret = s_pst_valid & no_err & s_pst_is_mret;
		ecall = s_pst_valid & no_err & s_pst_is_ecall; // ecall is still taken in a handler
		sw = mstatus_mie & mie_msie & sw_itr_req;
		tmr = mstatus_mie & mie_mtie & tmr_itr_req;
		ext = mstatus_mie & mie_meie & ext_itr_req;
		intr = sw | tmr | ext;
		lsu = ~busy & s_lsu_expt_valid;            // no nesting
		sync = ~busy & s_pst_valid & ~no_err;
		trap_req = intr | lsu | sync | ecall;
		e.is_intr = intr;
		if (ext)
			e.cause.intr_code = trap_pkg::intr_m_ext;
		else if (sw)
			e.cause.intr_code = trap_pkg::intr_m_sw;
		else if (tmr)
			e.cause.intr_code = trap_pkg::intr_m_tmr;
		else if (lsu)
		begin
			e.cause.expt_code = s_lsu_expt_err ? trap_pkg::expt_store_fault
				: trap_pkg::expt_load_fault;
			e.val = s_lsu_expt_addr;
		end
		else if (sync)
		begin
			case (s_pst_err_code)
				3'b010:
				begin
					e.cause.expt_code = trap_pkg::expt_inst_misaligned;
					e.val = s_pst_pc;
				end
				3'b011:
				begin
					e.cause.expt_code = trap_pkg::expt_inst_fault;
					e.val = s_pst_pc;
				end
				3'b110:
				begin
					e.cause.expt_code = trap_pkg::expt_load_misaligned;
					e.val = ls_addr;
				end
				3'b111:
				begin
					e.cause.expt_code = trap_pkg::expt_store_misaligned;
					e.val = ls_addr;
				end
				default: // 001 and the unused 101
				begin
					e.cause.expt_code = trap_pkg::expt_illegal_inst;
					e.val = s_pst_inst;
				end
			endcase
		end
		else if (ecall)
			e.cause.expt_code = trap_pkg::expt_ecall_m;
		e.ret_addr = sync ? s_pst_pc : s_pst_pc + 32'd4; // faulting inst is retried
		take_trap = ~misp & trap_req;
		take_mret = ~misp & ~trap_req & mret;
		e.enter = e.hs & take_trap;
		e.ret = e.hs & take_mret;
		e.lsu_ready = e.enter & ~intr & lsu;
		e.flush_req = e.hs & (misp | trap_req | mret | fence);
		e.flush_addr = take_trap ? itr_expt_vec_base
			: (take_mret ? mepc_ret_addr : s_pst_brc_pc_upd);
		e.cmt = ~sync;
		e.wbk = ~sync & ~s_pst_is_long;
		return e;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		stop_on_error($sformatf("FAIL %s: expected 0x%08h, got 0x%08h", name, exp_v, got_v));
	endtask

	task automatic check_commit(input logic ready_e, input logic valid_e, input logic hs_e,
		input logic cmt_e, input logic wbk_e, input logic lsu_ready_e);
		if (s_pst_ready !== ready_e)
			report_mismatch("s_pst_ready", ready_e, s_pst_ready);
		if (m_pst_valid !== valid_e)
			report_mismatch("m_pst_valid", valid_e, m_pst_valid);
		if (s_lsu_expt_ready !== lsu_ready_e)
			report_mismatch("s_lsu_expt_ready", lsu_ready_e, s_lsu_expt_ready);
		if (hs_e && (m_pst_inst_cmt !== cmt_e)) // only meaningful on handshake
			report_mismatch("m_pst_inst_cmt", cmt_e, m_pst_inst_cmt);
		if (hs_e && (m_pst_need_imdt_wbk !== wbk_e))
			report_mismatch("m_pst_need_imdt_wbk", wbk_e, m_pst_need_imdt_wbk);
	endtask

	task automatic check_trap(input logic enter_e, input logic ret_e, input logic is_intr_e,
		input trap_pkg::trap_cause_u cause_e, input logic [`COMMIT_XLEN-1:0] val_e,
		input logic [`COMMIT_XLEN-1:0] ret_addr_e);
		if (itr_expt_enter !== enter_e)
			report_mismatch("itr_expt_enter", enter_e, itr_expt_enter);
		if (itr_expt_ret !== ret_e)
			report_mismatch("itr_expt_ret", ret_e, itr_expt_ret);
		if (enter_e) // csr file samples the rest on enter
		begin
			if (itr_expt_is_intr !== is_intr_e)
				report_mismatch("itr_expt_is_intr", is_intr_e, itr_expt_is_intr);
			if (itr_expt_cause !== cause_e)
				report_mismatch("itr_expt_cause", cause_e, itr_expt_cause);
			if (itr_expt_val !== val_e)
				report_mismatch("itr_expt_val", val_e, itr_expt_val);
			if (itr_expt_ret_addr !== ret_addr_e)
				report_mismatch("itr_expt_ret_addr", ret_addr_e, itr_expt_ret_addr);
		end
	endtask

	task automatic check_flush(input logic req_e, input logic [`COMMIT_XLEN-1:0] addr_e);
		if (flush_req !== req_e)
			report_mismatch("flush_req", req_e, flush_req);
		if (req_e && (flush_addr !== addr_e))
			report_mismatch("flush_addr", addr_e, flush_addr);
	endtask

	// ack comes ack_delay cycles after the request, 0 means same cycle
	task automatic drive_flush_ack(input logic [1:0] new_delay);
		if (waiting)
		begin
			if (seen_ack)
			begin
				waiting = 1'b0;
				ack_delay = new_delay;
				flush_ack <= (new_delay == 2'd0);
			end
			else
			begin
				flush_ack <= (ack_cnt == 1);
				ack_cnt = ack_cnt - 1;
			end
		end
		else if (seen_req && !seen_ack)
		begin
			waiting = 1'b1;
			flush_ack <= (ack_delay == 2'd1);
			ack_cnt = int'(ack_delay) - 1;
		end
		else
		begin
			if (seen_req) // same-cycle ack used up, draw the next delay
				ack_delay = new_delay;
			flush_ack <= (ack_delay == 2'd0);
		end
	endtask

	task automatic drive_cycle();
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] pc_w;
		logic [2:0]  kind;
		f0 = rand_word();
		f1 = rand_word();
		pc_w = rand_word();
		kind = f0[5:3];
		s_pst_valid <= (f0[2:0] != 3'd0);
		s_pst_is_b <= (kind == 3'd1) || (kind == 3'd5); // branches twice as likely
		s_pst_is_ecall <= (kind == 3'd2);
		s_pst_is_mret <= (kind == 3'd3);
		s_pst_is_fence_i <= (kind == 3'd4);
		s_pst_prdt_jump <= f0[6];
		cfr_jump <= f0[7];
		s_pst_is_long <= f0[8];
		s_pst_err_code <= (f0[10:9] == 2'd0) ? f0[13:11] : 3'd0; // error in one of four
		m_pst_ready <= (f0[15:14] != 2'd0);
		s_lsu_expt_valid <= (f0[18:16] == 3'd0);
		s_lsu_expt_err <= f0[19];
		mstatus_mie <= f0[20];
		mie_msie <= (f0[22:21] != 2'd0);
		mie_mtie <= (f0[24:23] != 2'd0);
		mie_meie <= (f0[26:25] != 2'd0);
		sw_itr_req <= (f0[29:27] == 3'd0);
		tmr_itr_req <= (f1[2:0] == 3'd0);
		ext_itr_req <= (f1[5:3] == 3'd0);
		s_pst_pc <= {pc_w[31:2], 2'b00};
		s_pst_inst <= rand_word();
		s_pst_brc_pc_upd <= rand_word();
		ls_addr <= rand_word();
		s_lsu_expt_addr <= rand_word();
		itr_expt_vec_base <= rand_word();
		mepc_ret_addr <= rand_word();
		drive_flush_ack(f1[7:6]);
	endtask

	// compare every cycle at the falling edge, then step the model flags
	always @(negedge clk)
	begin
		if (resetn)
		begin
			exp_now = ref_model(busy_m, pend_m);
			check_commit(exp_now.ready, exp_now.valid, exp_now.hs, exp_now.cmt, exp_now.wbk,
				exp_now.lsu_ready);
			check_trap(exp_now.enter, exp_now.ret, exp_now.is_intr, exp_now.cause, exp_now.val,
				exp_now.ret_addr);
			check_flush(exp_now.flush_req, exp_now.flush_addr);
			if (exp_now.enter)
				busy_m = 1'b1;
			else if (exp_now.ret)
				busy_m = 1'b0;
			if (pend_m)
				n_stall = n_stall + 1;
			pend_m = (pend_m | exp_now.flush_req) & ~flush_ack; // same-cycle ack clears
			seen_req = exp_now.flush_req;
			seen_ack = flush_ack;
			if (exp_now.hs)
				inst_cnt = inst_cnt + 1;
			if (exp_now.enter && exp_now.is_intr)
				n_intr = n_intr + 1;
			if (exp_now.enter && !exp_now.is_intr)
				n_expt = n_expt + 1;
			if (exp_now.lsu_ready)
				n_lsu = n_lsu + 1;
			if (exp_now.ret)
				n_ret = n_ret + 1;
			if (exp_now.flush_req && !exp_now.enter && !exp_now.ret)
				n_redirect = n_redirect + 1; // mispredict or fence.i
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT)
			stop_on_error("timeout: the instruction count was not reached in time");
	end

	initial
	begin
		lcg_state = 32'd6;
		resetn = 1'b0;
		{mstatus_mie, mie_msie, mie_mtie, mie_meie} = 4'b0;
		{sw_itr_req, tmr_itr_req, ext_itr_req} = 3'b0;
		s_pst_valid = 1'b0;
		s_pst_inst = '0;
		s_pst_pc = '0;
		s_pst_brc_pc_upd = '0;
		s_pst_err_code = '0;
		{s_pst_is_b, s_pst_is_ecall, s_pst_is_mret, s_pst_is_fence_i} = 4'b0;
		{s_pst_prdt_jump, s_pst_is_long, cfr_jump} = 3'b0;
		s_lsu_expt_addr = '0;
		{s_lsu_expt_err, s_lsu_expt_valid} = 2'b0;
		m_pst_ready = 1'b0;
		ls_addr = '0;
		itr_expt_vec_base = '0;
		mepc_ret_addr = '0;
		busy_m = 1'b0;
		pend_m = 1'b0;
		seen_req = 1'b0;
		seen_ack = 1'b0;
		waiting = 1'b0;
		ack_cnt = 0;
		ack_delay = 2'd1;
		flush_ack = 1'b0;
		repeat (16) @(posedge clk);
		resetn <= 1'b1;
		while (inst_cnt < RUN_LEN)
		begin
			@(posedge clk);
			drive_cycle();
		end
		@(posedge clk); // last driven cycle has been checked by now
		if (n_intr == 0 || n_expt == 0 || n_lsu == 0 || n_ret == 0 || n_redirect == 0 ||
			n_stall == 0)
			stop_on_error("some event kinds never occurred during the run");
		else
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* commit_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "commit_defines.svh"

module commit_unit
(
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      mstatus_mie,
	input  logic                      mie_msie,
	input  logic                      mie_mtie,
	input  logic                      mie_meie,
	input  logic [`COMMIT_XLEN-1:0]   s_pst_inst,
	input  logic [`COMMIT_ERR_W-1:0]  s_pst_err_code,
	input  logic [`COMMIT_XLEN-1:0]   s_pst_pc,
	input  logic                      s_pst_is_b,
	input  logic                      s_pst_is_ecall,
	input  logic                      s_pst_is_mret,
	input  logic                      s_pst_is_fence_i,
	input  logic [`COMMIT_XLEN-1:0]   s_pst_brc_pc_upd,
	input  logic                      s_pst_prdt_jump,
	input  logic                      s_pst_is_long,
	input  logic                      s_pst_valid,
	output logic                      s_pst_ready,
	input  logic [`COMMIT_XLEN-1:0]   s_lsu_expt_addr,
	input  logic                      s_lsu_expt_err,   // 0 load, 1 store
	input  logic                      s_lsu_expt_valid,
	output logic                      s_lsu_expt_ready,
	output logic                      m_pst_inst_cmt,
	output logic                      m_pst_need_imdt_wbk,
	output logic                      m_pst_valid,
	input  logic                      m_pst_ready,
	input  logic [`COMMIT_XLEN-1:0]   ls_addr,
	input  logic                      cfr_jump,
	input  logic                      sw_itr_req,
	input  logic                      tmr_itr_req,
	input  logic                      ext_itr_req,
	output logic                      itr_expt_enter,
	output logic                      itr_expt_is_intr,
	output trap_pkg::trap_cause_u     itr_expt_cause,
	input  logic [`COMMIT_XLEN-1:0]   itr_expt_vec_base,
	output logic [`COMMIT_XLEN-1:0]   itr_expt_ret_addr,
	output logic [`COMMIT_XLEN-1:0]   itr_expt_val,
	output logic                      itr_expt_ret,
	input  logic [`COMMIT_XLEN-1:0]   mepc_ret_addr,
	output logic                      flush_req,
	input  logic                      flush_ack,
	output logic [`COMMIT_XLEN-1:0]   flush_addr
);

	pst_if  pst ();
	trap_if trap ();

	logic                     mispredict;
	logic                     fence_i;
	logic [`COMMIT_XLEN-1:0]  redirect_addr;

	assign pst.valid = s_pst_valid;
	assign pst.pc = s_pst_pc;
	assign pst.inst = s_pst_inst;
	assign pst.err_code = inst_pkg::err_code_e'(s_pst_err_code); // raw bits from decode
	assign pst.is_b = s_pst_is_b;
	assign pst.is_ecall = s_pst_is_ecall;
	assign pst.is_mret = s_pst_is_mret;
	assign pst.is_fence_i = s_pst_is_fence_i;
	assign pst.prdt_jump = s_pst_prdt_jump;
	assign pst.brc_pc_upd = s_pst_brc_pc_upd;
	assign pst.is_long = s_pst_is_long;
	assign s_pst_ready = pst.ready;

	// csr file side
	assign itr_expt_enter = trap.enter;
	assign itr_expt_is_intr = trap.is_intr;
	assign itr_expt_cause = trap.cause;
	assign itr_expt_ret_addr = trap.ret_addr;
	assign itr_expt_val = trap.val;
	assign itr_expt_ret = trap.ret;

	branch_resolver branch_resolver_i
	(
		.pst           (pst.brc),
		.cfr_jump      (cfr_jump),
		.mispredict    (mispredict),
		.fence_i       (fence_i),
		.redirect_addr (redirect_addr)
	);

	trap_arbiter trap_arbiter_i
	(
		.clk            (clk),
		.resetn         (resetn),
		.pst            (pst.trap),
		.trap           (trap.arb),
		.mstatus_mie    (mstatus_mie),
		.mie_msie       (mie_msie),
		.mie_mtie       (mie_mtie),
		.mie_meie       (mie_meie),
		.sw_itr_req     (sw_itr_req),
		.tmr_itr_req    (tmr_itr_req),
		.ext_itr_req    (ext_itr_req),
		.lsu_expt_valid (s_lsu_expt_valid),
		.lsu_expt_err   (s_lsu_expt_err),
		.lsu_expt_addr  (s_lsu_expt_addr),
		.ls_addr        (ls_addr)
	);

	commit_ctrl commit_ctrl_i
	(
		.clk                 (clk),
		.resetn              (resetn),
		.pst                 (pst.ctrl),
		.trap                (trap.ctrl),
		.mispredict          (mispredict),
		.fence_i             (fence_i),
		.redirect_addr       (redirect_addr),
		.m_pst_ready         (m_pst_ready),
		.m_pst_valid         (m_pst_valid),
		.m_pst_inst_cmt      (m_pst_inst_cmt),
		.m_pst_need_imdt_wbk (m_pst_need_imdt_wbk),
		.lsu_expt_ready      (s_lsu_expt_ready),
		.itr_expt_vec_base   (itr_expt_vec_base),
		.mepc_ret_addr       (mepc_ret_addr),
		.flush_req           (flush_req),
		.flush_ack           (flush_ack),
		.flush_addr          (flush_addr)
	);

endmodule

`default_nettype wire

/* commit_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "commit_defines.svh"

module commit_ctrl
(
	input  logic                     clk,
	input  logic                     resetn,
	pst_if.ctrl                      pst,
	trap_if.ctrl                     trap,
	input  logic                     mispredict,
	input  logic                     fence_i,
	input  logic [`COMMIT_XLEN-1:0]  redirect_addr,
	input  logic                     m_pst_ready,         // write-back side ready
	output logic                     m_pst_valid,
	output logic                     m_pst_inst_cmt,      // 0 cancels the inst
	output logic                     m_pst_need_imdt_wbk,
	output logic                     lsu_expt_ready,
	input  logic [`COMMIT_XLEN-1:0]  itr_expt_vec_base,   // mtvec
	input  logic [`COMMIT_XLEN-1:0]  mepc_ret_addr,
	output logic                     flush_req,
	input  logic                     flush_ack,
	output logic [`COMMIT_XLEN-1:0]  flush_addr
);

	logic flush_pend; // front end still busy flushing
	logic hs;         // instruction handshake this cycle
	logic take_brc;   // outcome ranking, one-hot or none
	logic take_trap;
	logic take_mret;
	logic take_fence;

	// hold everything while a flush is outstanding
	assign pst.ready = ~flush_pend & m_pst_ready;
	assign m_pst_valid = ~flush_pend & pst.valid;
	assign hs = pst.valid & pst.ready;

	// mispredict > trap > mret > fence.i
	assign take_brc = mispredict;
	assign take_trap = ~mispredict & trap.trap_req;
	assign take_mret = ~mispredict & ~trap.trap_req & trap.mret_ok;
	assign take_fence = ~mispredict & ~trap.trap_req & ~trap.mret_ok & fence_i;

	assign trap.enter = hs & take_trap;
	assign trap.ret = hs & take_mret;

	// lsu handshakes together with the instruction
	assign lsu_expt_ready = hs & take_trap & trap.lsu_sel;

	assign flush_req = hs & (take_brc | take_trap | take_mret | take_fence);

	always_comb
	begin
		if (take_trap)
			flush_addr = itr_expt_vec_base;
		else if (take_mret)
			flush_addr = mepc_ret_addr;
		else
			flush_addr = redirect_addr; // mispredict or fence.i
	end

	// only an accepted sync error cancels, interrupts let it retire
	assign m_pst_inst_cmt = ~trap.sync_err;
	assign m_pst_need_imdt_wbk = m_pst_inst_cmt & ~pst.is_long; // long ops write back later

	// same-cycle ack never sets the flag
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			flush_pend <= 1'b0;
		else
			flush_pend <= (flush_pend | flush_req) & ~flush_ack;
	end

endmodule

`default_nettype wire

/* trap_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "commit_defines.svh"

module trap_arbiter
(
	input  logic                     clk,
	input  logic                     resetn,
	pst_if.trap                      pst,
	trap_if.arb                      trap,
	input  logic                     mstatus_mie,    // global enable
	input  logic                     mie_msie,
	input  logic                     mie_mtie,
	input  logic                     mie_meie,
	input  logic                     sw_itr_req,     // level, held until cleared
	input  logic                     tmr_itr_req,
	input  logic                     ext_itr_req,
	input  logic                     lsu_expt_valid, // bus error from lsu
	input  logic                     lsu_expt_err,   // 0 load, 1 store
	input  logic [`COMMIT_XLEN-1:0]  lsu_expt_addr,
	input  logic [`COMMIT_XLEN-1:0]  ls_addr         // agu address of this inst
);

	logic                      trap_busy; // handler running
	logic                      no_err;
	logic                      sw_vld;    // enabled requests
	logic                      tmr_vld;
	logic                      ext_vld;
	logic                      intr_any;
	logic                      lsu_vld;   // lsu exception accepted
	logic                      sync_vld;  // sync error accepted
	logic                      ecall_vld;
	trap_pkg::trap_cause_u     cause_c;
	logic [`COMMIT_XLEN-1:0]   val_c;

	assign no_err = ~(pst.err_code[0] | pst.err_code[1]);

	// mie is cleared by the csr file on entry, which blocks nesting
	assign sw_vld = mstatus_mie & mie_msie & sw_itr_req;
	assign tmr_vld = mstatus_mie & mie_mtie & tmr_itr_req;
	assign ext_vld = mstatus_mie & mie_meie & ext_itr_req;
	assign intr_any = sw_vld | tmr_vld | ext_vld;

	// exceptions are dropped inside a handler
	assign lsu_vld = ~trap_busy & lsu_expt_valid;
	assign sync_vld = ~trap_busy & pst.valid & ~no_err;
	assign ecall_vld = pst.valid & no_err & pst.is_ecall;

	// priority ext > sw > tmr > lsu > sync > ecall
	always_comb
	begin
		cause_c = '0;
		val_c = '0; // interrupts and ecall report zero
		if (ext_vld)
			cause_c.intr_code = trap_pkg::intr_m_ext;
		else if (sw_vld)
			cause_c.intr_code = trap_pkg::intr_m_sw;
		else if (tmr_vld)
			cause_c.intr_code = trap_pkg::intr_m_tmr;
		else if (lsu_vld)
		begin
			if (lsu_expt_err)
				cause_c.expt_code = trap_pkg::expt_store_fault;
			else
				cause_c.expt_code = trap_pkg::expt_load_fault;
			val_c = lsu_expt_addr; // faulting bus address
		end
		else if (sync_vld)
		begin
			case (pst.err_code)
				inst_pkg::err_pc_unaligned:
				begin
					cause_c.expt_code = trap_pkg::expt_inst_misaligned;
					val_c = pst.pc;
				end
				inst_pkg::err_imem_fault:
				begin
					cause_c.expt_code = trap_pkg::expt_inst_fault;
					val_c = pst.pc;
				end
				inst_pkg::err_load_unaligned:
				begin
					cause_c.expt_code = trap_pkg::expt_load_misaligned;
					val_c = ls_addr;
				end
				inst_pkg::err_store_unaligned:
				begin
					cause_c.expt_code = trap_pkg::expt_store_misaligned;
					val_c = ls_addr;
				end
				default: // illegal, also the unused 3'b101
				begin
					cause_c.expt_code = trap_pkg::expt_illegal_inst;
					val_c = pst.inst;
				end
			endcase
		end
		else if (ecall_vld)
			cause_c.expt_code = trap_pkg::expt_ecall_m;
	end

	assign trap.trap_req = intr_any | lsu_vld | sync_vld | ecall_vld;
	assign trap.is_intr = intr_any;
	assign trap.cause = cause_c;
	assign trap.val = val_c;
	assign trap.lsu_sel = ~intr_any & lsu_vld;
	assign trap.sync_err = sync_vld;
	assign trap.mret_ok = pst.valid & no_err & pst.is_mret;

	// faulting inst is refetched, anything else resumes after it
	// so an ecall overtaken by an interrupt is skipped on return
	assign trap.ret_addr = sync_vld ? pst.pc : pst.pc + `COMMIT_XLEN'd4;

	// set after enter, cleared after mret
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			trap_busy <= 1'b0;
		else if (trap.enter | trap.ret)
			trap_busy <= trap.enter;
	end

endmodule

`default_nettype wire

/* branch_resolver.sv */
`timescale 1ns/100ps
`default_nettype none

`include "commit_defines.svh"

module branch_resolver
(
	pst_if.brc                       pst,
	input  logic                     cfr_jump,     // confirmed direction from alu
	output logic                     mispredict,
	output logic                     fence_i,
	output logic [`COMMIT_XLEN-1:0]  redirect_addr
);

	logic no_err; // instruction is error free
	logic dir_diff; // predicted and confirmed disagree

	// only codes with bit 0 or 1 set are real errors
	assign no_err = ~(pst.err_code[0] | pst.err_code[1]);

	assign dir_diff = pst.prdt_jump ^ cfr_jump;

	// a faulty branch traps instead, so it never redirects
	assign mispredict = pst.valid & no_err & pst.is_b & dir_diff;

	// fence.i refetches everything behind it
	assign fence_i = pst.valid & no_err & pst.is_fence_i;

	// decode already holds the right target for either case
	// for a branch it is the other side of the prediction,
	// for fence.i it is the next sequential pc
	assign redirect_addr = pst.brc_pc_upd;

endmodule

`default_nettype wire

/* commit_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "commit_defines.svh"

// pending instruction from the dispatch side
interface pst_if;
	logic                      valid;      // instruction waiting for commit
	logic [`COMMIT_XLEN-1:0]   pc;         // its pc
	logic [`COMMIT_XLEN-1:0]   inst;       // raw word, for illegal mtval
	inst_pkg::err_code_e       err_code;   // fetch/decode/agu error
	logic                      is_b;       // conditional branch
	logic                      is_ecall;
	logic                      is_mret;
	logic                      is_fence_i;
	logic                      prdt_jump;  // predicted taken
	logic [`COMMIT_XLEN-1:0]   brc_pc_upd; // corrected pc on redirect
	logic                      is_long;    // ld/st or mul/div, late wbk
	logic                      ready;      // commit accepts

	modport src  (output valid, pc, inst, err_code, is_b, is_ecall, is_mret, is_fence_i,
		prdt_jump, brc_pc_upd, is_long, input ready);
	modport brc  (input valid, err_code, is_b, is_fence_i, prdt_jump, brc_pc_upd);
	modport trap (input valid, pc, inst, err_code, is_ecall, is_mret);
	modport ctrl (input valid, is_long, output ready);
endinterface

// trap proposal from the arbiter, strobes back from the controller
interface trap_if;
	logic                      trap_req; // some trap would be taken
	logic                      is_intr;  // winner is an interrupt
	trap_pkg::trap_cause_u     cause;
	logic [`COMMIT_XLEN-1:0]   val;      // mtval
	logic [`COMMIT_XLEN-1:0]   ret_addr; // mepc
	logic                      lsu_sel;  // lsu exception wins
	logic                      sync_err; // accepted sync error, cancels commit
	logic                      mret_ok;  // error-free mret
	logic                      enter;    // trap taken this cycle
	logic                      ret;      // mret executed this cycle

	modport arb  (output trap_req, is_intr, cause, val, ret_addr, lsu_sel, sync_err, mret_ok,
		input enter, ret);
	modport ctrl (input trap_req, lsu_sel, sync_err, mret_ok, output enter, ret);
endinterface

`default_nettype wire

/* trap_pkg.sv */
`default_nettype none

`include "commit_defines.svh"

package trap_pkg;

	// machine mode interrupt codes, mcause with interrupt bit set
	typedef enum logic [`COMMIT_CAUSE_W-1:0]
	{
		intr_m_sw  = 8'd3,  // software
		intr_m_tmr = 8'd7,  // timer
		intr_m_ext = 8'd11  // external
	} intr_code_e;

	// exception codes, numbered as in the privileged spec
	typedef enum logic [`COMMIT_CAUSE_W-1:0]
	{
		expt_inst_misaligned  = 8'd0,  // fetch address misaligned
		expt_inst_fault       = 8'd1,  // fetch bus fault
		expt_illegal_inst     = 8'd2,  // illegal instruction
		expt_load_misaligned  = 8'd4,  // load address misaligned
		expt_load_fault       = 8'd5,  // load bus fault
		expt_store_misaligned = 8'd6,  // store address misaligned
		expt_store_fault      = 8'd7,  // store bus fault
		expt_ecall_m          = 8'd11  // ecall from m mode
	} expt_code_e;

	// one cause word, is_intr tells which view applies
	typedef union packed
	{
		intr_code_e intr_code; // view when is_intr is set
		expt_code_e expt_code; // view for exceptions and ecall
	} trap_cause_u;

	// the csr file writes {is_intr, cause} into mcause

endpackage

`default_nettype wire

/* inst_pkg.sv */
`default_nettype none

`include "commit_defines.svh"

package inst_pkg;

	// error attached to a pending instruction by fetch, decode or agu
	// bit 0 or bit 1 set means a synchronous error
	typedef enum logic [`COMMIT_ERR_W-1:0]
	{
		err_normal          = 3'b000, // no error
		err_illegal         = 3'b001, // illegal instruction
		err_pc_unaligned    = 3'b010, // misaligned fetch address
		err_imem_fault      = 3'b011, // instruction bus fault
		err_load_unaligned  = 3'b110, // misaligned load address
		err_store_unaligned = 3'b111  // misaligned store address
	} err_code_e;

	// the four codes above 3'b011 without bit 0/1 are never produced
	// by decode, 3'b100 reads as error free and 3'b101 as illegal

	// bits 0 and 1 of the code mark an error the commit stage must trap on
	// bit 2 separates data side errors from instruction side ones
	// instruction side errors report the pc or the word as mtval
	// data side errors report the address from the agu

endpackage

`default_nettype wire

/* commit_defines.svh */
`ifndef COMMIT_DEFINES_SVH
`define COMMIT_DEFINES_SVH

// widths shared by the commit stage packages, interfaces and modules

// rv32 data and address width
`define COMMIT_XLEN 32

// mcause code field, interrupt and exception codes alike
`define COMMIT_CAUSE_W 8

// error code carried by each pending instruction
`define COMMIT_ERR_W 3

// msb index helpers
`define COMMIT_XLEN_MSB (`COMMIT_XLEN - 1)
`define COMMIT_CAUSE_MSB (`COMMIT_CAUSE_W - 1)

`endif
